//--- design/corr_defines.svh
/* sizes and the fixed tap pattern of the lane correlator.
   include this wherever a width, a count or the pattern is needed */
`ifndef CORR_DEFINES_SVH
`define CORR_DEFINES_SVH

// channels per beat, one lane each
`define CORR_CHANNELS 4
`define CORR_LANE_W 2

// signed sample and accumulator widths
`define CORR_SAMPLE_W 8
`define CORR_ACC_W 13
`define CORR_OUT_W 16

// correlator length
`define CORR_TAPS 8

// bit n set gives +1 on tap n, clear gives -1
`define CORR_COEFFS 8'b1011_0010

`endif

//--- design/corr_pkg.sv
/* vector types and the sequencer state encoding shared by the correlator blocks */
`default_nettype none

`include "corr_defines.svh"

package corr_pkg;

  // one signed sample and a packed beat, lane 0 in the low bits
  typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;
  typedef logic [`CORR_CHANNELS*`CORR_SAMPLE_W-1:0] beat_t;

  // chain value, wide enough for taps x 128
  typedef logic signed [`CORR_ACC_W-1:0] acc_t;

  // output lane and packed output word
  typedef logic signed [`CORR_OUT_W-1:0] out_lane_t;
  typedef logic [`CORR_CHANNELS*`CORR_OUT_W-1:0] out_beat_t;

  typedef logic [`CORR_LANE_W-1:0] lane_t;

  typedef enum logic [1:0] {IDLE, RUN, COMMIT} seq_state_t;

endpackage

`default_nettype wire

//--- design/lane_counter.sv
/* lane index of the beat in progress; advances once per step and
   flags the final lane so the sequencer knows when the beat is done */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module lane_counter (
  input  wire            clk,
  input  wire            rst,
  input  wire            clear,
  input  wire            step,
  output corr_pkg::lane_t lane,
  output logic           last
);

  always_ff @(posedge clk) begin
    if (rst) begin
      lane <= '0;
    end else if (clear) begin
      lane <= '0;
    end else if (step) begin
      lane <= lane + 1'b1;
    end
  end

  // final lane of the beat
  assign last = (lane == corr_pkg::lane_t'(`CORR_CHANNELS - 1));

  //////////////////////////////
  // checks

  // a step on the last lane wraps to 0 and ends the step burst
  a_wrap_ends_run: assert property (
    @(posedge clk) disable iff (rst)
    (step && last && !clear) |=> (lane == '0 && !step)
  );

endmodule

`default_nettype wire

//--- design/corr_sequencer.sv
/* beat FSM: takes one input beat, steps every lane through the shared chain,
   then hands the result to the output slot as soon as it is free */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module corr_sequencer (
  input  wire  clk,
  input  wire  rst,
  input  wire  in_valid,
  output logic in_ready,
  input  wire  last,
  input  wire  slot_busy,
  output logic load,
  output logic clear,
  output logic step,
  output logic commit
);

  corr_pkg::seq_state_t state;
  corr_pkg::seq_state_t state_nxt;

  //////////////////////////////
  // state register

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= corr_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      corr_pkg::IDLE: begin
        if (in_valid) begin
          state_nxt = corr_pkg::RUN;
        end
      end
      corr_pkg::RUN: begin
        // the step on the last lane closes the beat
        if (last) begin
          state_nxt = corr_pkg::COMMIT;
        end
      end
      corr_pkg::COMMIT: begin
        if (!slot_busy) begin
          state_nxt = corr_pkg::IDLE;
        end
      end
      default: state_nxt = corr_pkg::IDLE;
    endcase
  end

  //////////////////////////////
  // outputs

  assign in_ready = (state == corr_pkg::IDLE);

  // input transfer latches the beat and rewinds the lane counter
  assign load = in_valid && in_ready;
  assign clear = load;

  assign step = (state == corr_pkg::RUN);
  assign commit = (state == corr_pkg::COMMIT) && !slot_busy;

  // checks

  // the output slot only fills through a commit into a free slot
  a_slot_filled_by_commit: assert property (
    @(posedge clk) disable iff (rst)
    $rose(slot_busy) |-> $past(commit)
  );

  // one step per lane after a load, and steps only while running
  a_step_burst: assert property (
    @(posedge clk) disable iff (rst)
    load |=> (step && state == corr_pkg::RUN) [*`CORR_CHANNELS]
      ##1 (!step && state == corr_pkg::COMMIT)
  );

endmodule

`default_nettype wire

//--- design/tap_chain.sv
/* shared add/subtract chain; one lane per step, each tap keeps its partial
   sum per lane in a small memory so every channel has its own history */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module tap_chain (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   load,
  input  wire corr_pkg::beat_t  in_data,
  input  wire                   step,
  input  wire corr_pkg::lane_t  lane,
  output corr_pkg::out_lane_t   result,
  output corr_pkg::lane_t       result_lane
);

  localparam logic [`CORR_TAPS-1:0] COEFFS = `CORR_COEFFS;

  corr_pkg::beat_t   beat_q;
  corr_pkg::sample_t sample;
  corr_pkg::acc_t    sample_ext;

  // partial sums, one lane entry per tap below the last
  corr_pkg::acc_t tap_mem [`CORR_TAPS-1][`CORR_CHANNELS];

  corr_pkg::acc_t tap_in  [`CORR_TAPS];
  corr_pkg::acc_t tap_sum [`CORR_TAPS];

  //////////////////////////////
  // input beat and lane select

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q <= in_data;
    end
  end

  assign sample = corr_pkg::sample_t'(beat_q[lane*`CORR_SAMPLE_W +: `CORR_SAMPLE_W]);
  assign sample_ext = corr_pkg::acc_t'(sample);

  //////////////////////////////
  // adder chain

  // tap 0 starts from zero
  assign tap_in[0] = '0;

  for (genvar n = 1; n < `CORR_TAPS; n++) begin : g_tap_in
    assign tap_in[n] = tap_mem[n-1][lane];
  end

  for (genvar n = 0; n < `CORR_TAPS; n++) begin : g_tap_sum
    assign tap_sum[n] = COEFFS[n] ? tap_in[n] + sample_ext : tap_in[n] - sample_ext;
  end

  // lane memories, written as the step ends
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < `CORR_TAPS - 1; t++) begin
        for (int c = 0; c < `CORR_CHANNELS; c++) begin
          tap_mem[t][c] <= '0;
        end
      end
    end else if (step) begin
      for (int t = 0; t < `CORR_TAPS - 1; t++) begin
        tap_mem[t][lane] <= tap_sum[t];
      end
    end
  end

  // last tap is the correlation for this lane
  assign result = corr_pkg::out_lane_t'(tap_sum[`CORR_TAPS-1]);
  assign result_lane = lane;

endmodule

`default_nettype wire

//--- design/result_packer.sv
/* gathers lane results into a staging word and moves it to the registered
   output on commit; the output holds until the consumer takes it */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module result_packer (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     step,
  input  wire corr_pkg::lane_t    result_lane,
  input  wire corr_pkg::out_lane_t result,
  input  wire                     commit,
  input  wire                     out_ready,
  output logic                    out_valid,
  output corr_pkg::out_beat_t     out_data,
  output logic                    slot_busy
);

  corr_pkg::out_beat_t stage;

  //////////////////////////////
  // staging word

  always_ff @(posedge clk) begin
    if (step) begin
      stage[result_lane*`CORR_OUT_W +: `CORR_OUT_W] <= result;
    end
  end

  //////////////////////////////
  // output slot

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (commit) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // consumer took the word, or slot already empty
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      out_data <= stage;
    end
  end

  // word waiting and not taken this cycle
  assign slot_busy = out_valid && !out_ready;

  a_hold_stalled: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

`default_nettype wire

//--- design/bit_correlator.sv
/* four-channel +/-1 correlator with valid/ready streams on both sides;
   one beat in, one packed 16-bit-per-lane result out */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module bit_correlator (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      in_valid,
  output logic                     in_ready,
  input  wire corr_pkg::beat_t     in_data,
  output logic                     out_valid,
  input  wire                      out_ready,
  output corr_pkg::out_beat_t      out_data
);

  logic                load;
  logic                clear;
  logic                step;
  logic                commit;
  logic                last;
  logic                slot_busy;
  corr_pkg::lane_t     lane;
  corr_pkg::lane_t     result_lane;
  corr_pkg::out_lane_t result;

  corr_sequencer corr_sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .last      (last),
    .slot_busy (slot_busy),
    .load      (load),
    .clear     (clear),
    .step      (step),
    .commit    (commit)
  );

  lane_counter lane_counter_i (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .step  (step),
    .lane  (lane),
    .last  (last)
  );

  tap_chain tap_chain_i (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .in_data     (in_data),
    .step        (step),
    .lane        (lane),
    .result      (result),
    .result_lane (result_lane)
  );

  result_packer result_packer_i (
    .clk         (clk),
    .rst         (rst),
    .step        (step),
    .result_lane (result_lane),
    .result      (result),
    .commit      (commit),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .slot_busy   (slot_busy)
  );

endmodule

`default_nettype wire

//--- testbench/tb_bit_correlator.sv
/* testbench for the four-channel correlator: applies a table of beats with idle
   gaps and output stalls, and checks each output word against a reference model */
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module tb_bit_correlator;

  localparam int NUM = 30;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY = 5;
  localparam logic [`CORR_TAPS-1:0] COEFFS = `CORR_COEFFS;

  typedef struct packed {
    logic            rnd;
    corr_pkg::beat_t beat;
    int              gap;
    int              stall;
  } entry_t;

  // beat comes from the xorshift generator when rnd is set
  localparam entry_t STIM [NUM] = '{
    '{1'b0, 32'h0403_0201, 0, 0}, '{1'b0, 32'h807f_ff01, 2, 0},
    '{1'b1, 32'h0000_0000, 0, 0}, '{1'b1, 32'h0000_0000, 1, 3},
    '{1'b1, 32'h0000_0000, 0, 7}, '{1'b1, 32'h0000_0000, 3, 1},
    // long run of +127
    '{1'b0, 32'h7f7f_7f7f, 0, 0}, '{1'b0, 32'h7f7f_7f7f, 0, 0},
    '{1'b0, 32'h7f7f_7f7f, 0, 2}, '{1'b0, 32'h7f7f_7f7f, 1, 0},
    '{1'b0, 32'h7f7f_7f7f, 0, 0}, '{1'b0, 32'h7f7f_7f7f, 0, 5},
    '{1'b0, 32'h7f7f_7f7f, 0, 0}, '{1'b0, 32'h7f7f_7f7f, 2, 0},
    // entries 14 to 21 oppose every tap sign for the most negative sum
    '{1'b0, 32'h7f7f_7f7f, 0, 0}, '{1'b0, 32'h8080_8080, 0, 0},
    '{1'b0, 32'h7f7f_7f7f, 0, 1}, '{1'b0, 32'h7f7f_7f7f, 0, 0},
    '{1'b0, 32'h8080_8080, 3, 0}, '{1'b0, 32'h8080_8080, 0, 6},
    '{1'b0, 32'h7f7f_7f7f, 0, 0}, '{1'b0, 32'h8080_8080, 1, 0},
    // the -128 run carries on past the tap length
    '{1'b0, 32'h8080_8080, 0, 4}, '{1'b0, 32'h8080_8080, 0, 0},
    '{1'b0, 32'h8080_8080, 0, 0}, '{1'b0, 32'h8080_8080, 0, 2},
    '{1'b0, 32'h8080_8080, 2, 0}, '{1'b0, 32'h8080_8080, 0, 0},
    '{1'b0, 32'h8080_8080, 0, 7}, '{1'b0, 32'h8080_8080, 0, 0}
  };

  logic                clk = 1'b0;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  corr_pkg::beat_t     in_data;
  logic                out_valid;
  logic                out_ready;
  corr_pkg::out_beat_t out_data;

  corr_pkg::sample_t   hist [`CORR_CHANNELS][`CORR_TAPS];
  corr_pkg::out_beat_t exp_q [$];
  int                  start_q [$];
  logic [31:0]         rng_state = 32'h521a_6350;
  int                  cyc = 0;
  int                  in_count = 0;
  int                  out_count = 0;
  int                  last_take = 0;
  int                  limit = 0;

  bit_correlator bit_correlator_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #10 clk = ~clk;

  // edge numbers of transfers on both streams
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (in_valid && in_ready) begin
      in_count <= in_count + 1;
      start_q.push_back(cyc + 1);
    end
    if (out_valid && out_ready) begin
      out_count <= out_count + 1;
      last_take <= cyc + 1;
    end
  end

  always @(negedge clk) begin
    if (limit > 0 && cyc > limit) begin
      abort_run($sformatf("simulation timed out after %0d clock cycles", limit));
    end
  end

  //////////////////////////////
  // helpers

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_beat(input corr_pkg::out_beat_t got, input corr_pkg::out_beat_t want,
                            input string what);
    corr_pkg::out_lane_t g;
    corr_pkg::out_lane_t w;
    for (int ch = 0; ch < `CORR_CHANNELS; ch++) begin
      g = got[ch*`CORR_OUT_W +: `CORR_OUT_W];
      w = want[ch*`CORR_OUT_W +: `CORR_OUT_W];
      if (g !== w) begin
        abort_run($sformatf("Mismatch at %0d ns: %s lane %0d got %0d expected %0d",
                            $time, what, ch, g, w));
      end
    end
  endtask

  task automatic check_latency(input int got, input int want);
    if (got != want) begin
      abort_run($sformatf("Mismatch at %0d ns: output latency %0d cycles, expected %0d",
                          $time, got, want));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      abort_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // shift each channel's history and form sum of c[n] * x[b-7+n]
  task automatic predict(input corr_pkg::beat_t beat, output corr_pkg::out_beat_t word);
    int sum;
    word = '0;
    for (int ch = 0; ch < `CORR_CHANNELS; ch++) begin
      for (int k = `CORR_TAPS - 1; k > 0; k--) begin
        hist[ch][k] = hist[ch][k-1];
      end
      hist[ch][0] = corr_pkg::sample_t'(beat[ch*`CORR_SAMPLE_W +: `CORR_SAMPLE_W]);
      sum = 0;
      for (int n = 0; n < `CORR_TAPS; n++) begin
        // tap n sees the sample from 7 - n beats back
        if (COEFFS[n]) begin
          sum = sum + int'(hist[ch][`CORR_TAPS-1-n]);
        end else begin
          sum = sum - int'(hist[ch][`CORR_TAPS-1-n]);
        end
      end
      word[ch*`CORR_OUT_W +: `CORR_OUT_W] = corr_pkg::out_lane_t'(sum);
    end
  endtask

  //////////////////////////////
  // input side

  initial begin : stimulus
    corr_pkg::beat_t     beat;
    corr_pkg::out_beat_t expect_word;
    int                  max_gap;
    int                  max_stall;
    max_gap = 0;
    max_stall = 0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    for (int ch = 0; ch < `CORR_CHANNELS; ch++) begin
      for (int k = 0; k < `CORR_TAPS; k++) begin
        hist[ch][k] = '0;
      end
    end
    for (int i = 0; i < NUM; i++) begin
      if (STIM[i].gap > max_gap) max_gap = STIM[i].gap;
      if (STIM[i].stall > max_stall) max_stall = STIM[i].stall;
    end
    limit = RESET_CYCLES + 50 + NUM * (6 + max_stall + max_gap);
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_flag(in_ready, 1'b1, "in_ready after reset");
    check_flag(out_valid, 1'b0, "out_valid after reset");
    for (int i = 0; i < NUM; i++) begin
      repeat (STIM[i].gap) @(negedge clk);
      if (STIM[i].rnd) begin
        rng_state = xorshift(rng_state);
        beat = rng_state;
      end else begin
        beat = STIM[i].beat;
      end
      predict(beat, expect_word);
      exp_q.push_back(expect_word);
      in_valid = 1'b1;
      in_data = beat;
      while (!in_ready) @(negedge clk);
      // transfer on the coming rising edge
      @(negedge clk);
      in_valid = 1'b0;
    end
    while (out_count < NUM) @(negedge clk);
    @(negedge clk);
    if (exp_q.size() != 0 || out_valid) begin
      abort_run("output stream ended with words missing or an extra word pending");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  //////////////////////////////
  // output side

  initial begin : monitor
    corr_pkg::out_beat_t held;
    int                  word;
    int                  start;
    int                  rise;
    word = 0;
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (out_valid) begin
        if (exp_q.size() == 0 || start_q.size() == 0) begin
          abort_run("output word arrived with no input beat outstanding");
        end else begin
          // a new word rises 5 cycles after its input unless the slot was still full
          start = start_q.pop_front();
          rise = start + LATENCY;
          if (last_take > rise) rise = last_take;
          check_latency(cyc - start, rise - start);
          check_beat(out_data, exp_q.pop_front(), "out_data");
          held = out_data;
          repeat (STIM[word].stall) begin
            out_ready = 1'b0;
            @(negedge clk);
            check_flag(out_valid, 1'b1, "out_valid during stall");
            check_beat(out_data, held, "stalled out_data");
            if (in_count - out_count >= 2) begin
              check_flag(in_ready, 1'b0, "in_ready with a finished beat waiting");
            end
          end
          out_ready = 1'b1;
          word++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/corr_pkg.sv
design/lane_counter.sv
design/corr_sequencer.sv
design/tap_chain.sv
design/result_packer.sv
design/bit_correlator.sv
testbench/tb_bit_correlator.sv

//--- Makefile
# Verilator build and run of the bit correlator testbench
# any variable below can be set on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_bit_correlator
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
